/* src/bcam_defs.svh */
`ifndef BCAM_DEFS_SVH
`define BCAM_DEFS_SVH

// ------------------------------------------------------------
// BCAM geometry
// ------------------------------------------------------------

// Entry width, also the compare word width
`define BCAM_DWIDTH 16

// Number of entries in the array
`define BCAM_ENTRIES 8

// Entry index width, log2 of the entry count
`define BCAM_AWIDTH 3

// ------------------------------------------------------------
// Response analyzer
// ------------------------------------------------------------

// Saturating failure counter width
`define BCAM_CNTW 8

`endif

/* src/bcam_mbist_pkg.sv */
`include "bcam_defs.svh"

package bcam_mbist_pkg;

   // One stored entry or one compare word
   typedef logic [`BCAM_DWIDTH-1:0] cam_data_t;

   // Entry index
   typedef logic [`BCAM_AWIDTH-1:0] cam_addr_t;

   // One hit bit per entry
   // Bit i set when entry i equals the compare word
   typedef logic [`BCAM_ENTRIES-1:0] match_vec_t;

   // Saturating BIST failure count
   typedef logic [`BCAM_CNTW-1:0] fail_cnt_t;

   // MBIST sequencer phases
   typedef enum logic [1:0] {
      IDLE,
      WRITE,
      COMPARE,
      DRAIN
   } bist_phase_e;

endpackage

/* src/bcam_mbist_ctrl.sv */
`timescale 1ns/100ps
`include "bcam_defs.svh"

module bcam_mbist_ctrl (
   input  logic                      bist_clk,
   input  logic                      rst_b,
   input  logic                      start,
   input  bcam_mbist_pkg::cam_data_t background,
   input  logic                      inv,
   output logic                      bist_busy,
   output logic                      bist_done,
   output logic                      cm_mode,
   output logic                      data_inv,
   output logic                      mask_en,
   output logic                      rotate_mask,
   output logic                      bist_wr_en,
   output bcam_mbist_pkg::cam_addr_t bist_wr_addr,
   output bcam_mbist_pkg::cam_data_t bist_wr_data,
   output logic                      bist_cm_en,
   output logic                      chk_en,
   output logic                      exp_hit,
   output logic                      run_start
);

   import bcam_mbist_pkg::*;

   // Two compares per mask bit position
   localparam int STEPW = $clog2(2 * `BCAM_DWIDTH);

   bist_phase_e      phase;
   cam_addr_t        entry_cnt;
   logic [STEPW-1:0] step_cnt;
   cam_data_t        bg_q;
   logic             inv_q;
   logic             go;

   // Start is only taken from idle
   assign go = (phase == IDLE) && start;

   // ------------------------------------------------------------
   // Phase sequencer
   // ------------------------------------------------------------
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         phase     <= IDLE;
         entry_cnt <= '0;
         step_cnt  <= '0;
         bist_busy <= 1'b0;
         bist_done <= 1'b0;
         run_start <= 1'b0;
         inv_q     <= 1'b0;
      end else begin
         // Pulses default low
         bist_done <= 1'b0;
         run_start <= go;
         case (phase)
            IDLE: begin
               if (start) begin
                  phase     <= WRITE;
                  bist_busy <= 1'b1;
                  inv_q     <= inv;
                  entry_cnt <= '0;
               end
            end
            WRITE: begin
               // One entry per cycle, 0 upward
               entry_cnt <= entry_cnt + 1'b1;
               if (entry_cnt == cam_addr_t'(`BCAM_ENTRIES - 1)) begin
                  phase    <= COMPARE;
                  step_cnt <= '0;
               end
            end
            COMPARE: begin
               step_cnt <= step_cnt + 1'b1;
               if (step_cnt == STEPW'(2 * `BCAM_DWIDTH - 1)) begin
                  phase <= DRAIN;
               end
            end
            DRAIN: begin
               // Last check lands in this cycle
               phase     <= IDLE;
               bist_busy <= 1'b0;
               bist_done <= 1'b1;
            end
            default: begin
               phase <= IDLE;
            end
         endcase
      end
   end

   // Background word held for the whole run
   always_ff @(posedge bist_clk) begin
      if (go) begin
         bg_q <= background;
      end
   end

   // ------------------------------------------------------------
   // Check alignment with the registered match vector
   // ------------------------------------------------------------
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         chk_en  <= 1'b0;
         exp_hit <= 1'b0;
      end else begin
         chk_en  <= bist_cm_en;
         // Unmasked step expects all hit
         exp_hit <= ~mask_en;
      end
   end

   // Write port drive
   assign bist_wr_en   = (phase == WRITE);
   assign bist_wr_addr = entry_cnt;
   assign bist_wr_data = bg_q;
   assign data_inv     = inv_q;

   // Odd steps are masked, mask advances after each of them
   assign cm_mode      = (phase == COMPARE);
   assign bist_cm_en   = (phase == COMPARE);
   assign mask_en      = (phase == COMPARE) && step_cnt[0];
   assign rotate_mask  = (phase == COMPARE) && step_cnt[0];

endmodule

/* src/bcam_mbist_inhandler.sv */
`timescale 1ns/100ps
`include "bcam_defs.svh"

module bcam_mbist_inhandler (
   input  logic                      bist_clk,
   input  logic                      rst_b,
   input  logic                      cm_mode,
   input  logic                      data_inv,
   input  logic                      mask_en,
   input  logic                      rotate_mask,
   input  bcam_mbist_pkg::cam_data_t bist_wr_data,
   input  bcam_mbist_pkg::cam_data_t func_cm_data,
   output bcam_mbist_pkg::cam_data_t wr_data_out,
   output bcam_mbist_pkg::cam_data_t cm_data_out
);

   import bcam_mbist_pkg::*;

   cam_data_t bist_mask;
   cam_data_t bist_cm_data;
   cam_data_t inv_word;
   cam_data_t mask_word;

   // ------------------------------------------------------------
   // Rotating one-hot mask
   // ------------------------------------------------------------

   // Shifts toward the MSB, top bit wraps into bit 0
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         bist_mask <= cam_data_t'(1);
      end else if (rotate_mask) begin
         bist_mask <= {bist_mask[`BCAM_DWIDTH-2:0], bist_mask[`BCAM_DWIDTH-1]};
      end
   end

   // ------------------------------------------------------------
   // Write and compare data
   // ------------------------------------------------------------

   // Inversion flag spread over the word
   assign inv_word    = {`BCAM_DWIDTH{data_inv}};
   assign wr_data_out = bist_wr_data ^ inv_word;

   // Mask only applies on masked steps
   assign mask_word    = bist_mask & {`BCAM_DWIDTH{mask_en}};

   // One bit flipped gives an all-miss compare
   assign bist_cm_data = wr_data_out ^ mask_word;

   // BIST word while in compare mode, else the functional one
   assign cm_data_out  = cm_mode ? bist_cm_data : func_cm_data;

endmodule

/* src/bcam_array.sv */
`timescale 1ns/100ps
`include "bcam_defs.svh"

module bcam_array (
   input  logic                       bist_clk,
   input  logic                       rst_b,
   input  logic                       bist_wr_en,
   input  bcam_mbist_pkg::cam_addr_t  bist_wr_addr,
   input  bcam_mbist_pkg::cam_data_t  bist_wr_data,
   input  logic                       func_wr_en,
   input  bcam_mbist_pkg::cam_addr_t  func_wr_addr,
   input  bcam_mbist_pkg::cam_data_t  func_wr_data,
   input  logic                       cm_en,
   input  bcam_mbist_pkg::cam_data_t  cm_data,
   output bcam_mbist_pkg::match_vec_t match,
   output logic                       match_valid
);

   import bcam_mbist_pkg::*;

   // Entry storage, undefined until written
   cam_data_t  mem [`BCAM_ENTRIES];
   match_vec_t hit;

   // ------------------------------------------------------------
   // Write port
   // ------------------------------------------------------------

   // BIST write wins a same-cycle collision
   always_ff @(posedge bist_clk) begin
      if (bist_wr_en) begin
         mem[bist_wr_addr] <= bist_wr_data;
      end else if (func_wr_en) begin
         mem[func_wr_addr] <= func_wr_data;
      end
   end

   // ------------------------------------------------------------
   // Compare port
   // ------------------------------------------------------------

   // Parallel equality against every entry
   always_comb begin
      for (int i = 0; i < `BCAM_ENTRIES; i++) begin
         hit[i] = (mem[i] == cm_data);
      end
   end

   // Result registered, so a same-cycle write is not yet seen
   always_ff @(posedge bist_clk) begin
      if (cm_en) begin
         match <= hit;
      end
   end

   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         match_valid <= 1'b0;
      end else begin
         match_valid <= cm_en;
      end
   end

endmodule

/* src/bcam_mbist_resp.sv */
`timescale 1ns/100ps

module bcam_mbist_resp (
   input  logic                       bist_clk,
   input  logic                       rst_b,
   input  logic                       run_start,
   input  logic                       chk_en,
   input  logic                       exp_hit,
   input  bcam_mbist_pkg::match_vec_t match,
   output logic                       bist_fail,
   output bcam_mbist_pkg::fail_cnt_t  fail_count
);

   import bcam_mbist_pkg::*;

   match_vec_t exp_vec;
   logic       miscompare;

   // ------------------------------------------------------------
   // Expected vector
   // ------------------------------------------------------------

   // All entries hold the same word, so all hit or all miss
   assign exp_vec    = exp_hit ? '1 : '0;
   assign miscompare = chk_en && (match != exp_vec);

   // ------------------------------------------------------------
   // Sticky flag and saturating count
   // ------------------------------------------------------------
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         bist_fail  <= 1'b0;
         fail_count <= '0;
      end else if (run_start) begin
         // Fresh run
         bist_fail  <= 1'b0;
         fail_count <= '0;
      end else if (miscompare) begin
         bist_fail <= 1'b1;
         // Hold at full scale
         if (fail_count != '1) begin
            fail_count <= fail_count + 1'b1;
         end
      end
   end

endmodule

/* src/bcam_mbist_top.sv */
`timescale 1ns/100ps

module bcam_mbist_top (
   input  logic                       bist_clk,
   input  logic                       rst_b,
   input  logic                       start,
   input  logic                       inv,
   input  logic                       func_wr_en,
   input  logic                       func_cm_en,
   input  bcam_mbist_pkg::cam_data_t  background,
   input  bcam_mbist_pkg::cam_data_t  func_wr_data,
   input  bcam_mbist_pkg::cam_data_t  func_cm_data,
   input  bcam_mbist_pkg::cam_addr_t  func_wr_addr,
   output bcam_mbist_pkg::match_vec_t match,
   output logic                       match_valid,
   output logic                       bist_busy,
   output logic                       bist_done,
   output logic                       bist_fail,
   output bcam_mbist_pkg::fail_cnt_t  fail_count
);

   import bcam_mbist_pkg::*;

   logic      cm_mode;
   logic      data_inv;
   logic      mask_en;
   logic      rotate_mask;
   logic      bist_wr_en;
   cam_addr_t bist_wr_addr;
   cam_data_t bist_wr_data;
   cam_data_t wr_data_out;
   cam_data_t cm_data_out;
   logic      bist_cm_en;
   logic      chk_en;
   logic      exp_hit;
   logic      run_start;
   logic      cm_en;

   // Functional compares dropped while the BIST runs
   assign cm_en = bist_cm_en | (func_cm_en & ~bist_busy);

   // ------------------------------------------------------------
   // Sequencer, data path, array, analyzer
   // ------------------------------------------------------------
   bcam_mbist_ctrl u_ctrl (
      .bist_clk     (bist_clk),
      .rst_b        (rst_b),
      .start        (start),
      .background   (background),
      .inv          (inv),
      .bist_busy    (bist_busy),
      .bist_done    (bist_done),
      .cm_mode      (cm_mode),
      .data_inv     (data_inv),
      .mask_en      (mask_en),
      .rotate_mask  (rotate_mask),
      .bist_wr_en   (bist_wr_en),
      .bist_wr_addr (bist_wr_addr),
      .bist_wr_data (bist_wr_data),
      .bist_cm_en   (bist_cm_en),
      .chk_en       (chk_en),
      .exp_hit      (exp_hit),
      .run_start    (run_start)
   );

   bcam_mbist_inhandler u_inhandler (
      .bist_clk     (bist_clk),
      .rst_b        (rst_b),
      .cm_mode      (cm_mode),
      .data_inv     (data_inv),
      .mask_en      (mask_en),
      .rotate_mask  (rotate_mask),
      .bist_wr_data (bist_wr_data),
      .func_cm_data (func_cm_data),
      .wr_data_out  (wr_data_out),
      .cm_data_out  (cm_data_out)
   );

   // BIST write data arrives already inverted
   bcam_array u_array (
      .bist_clk     (bist_clk),
      .rst_b        (rst_b),
      .bist_wr_en   (bist_wr_en),
      .bist_wr_addr (bist_wr_addr),
      .bist_wr_data (wr_data_out),
      .func_wr_en   (func_wr_en),
      .func_wr_addr (func_wr_addr),
      .func_wr_data (func_wr_data),
      .cm_en        (cm_en),
      .cm_data      (cm_data_out),
      .match        (match),
      .match_valid  (match_valid)
   );

   bcam_mbist_resp u_resp (
      .bist_clk   (bist_clk),
      .rst_b      (rst_b),
      .run_start  (run_start),
      .chk_en     (chk_en),
      .exp_hit    (exp_hit),
      .match      (match),
      .bist_fail  (bist_fail),
      .fail_count (fail_count)
   );

endmodule

/* sim/bcam_mbist_properties.sv */
`timescale 1ns/100ps

module bcam_mbist_properties (
   input logic                      bist_clk,
   input logic                      rst_b,
   input logic                      bist_busy,
   input logic                      bist_done,
   input logic                      cm_en,
   input logic                      match_valid,
   input logic                      run_start,
   input bcam_mbist_pkg::fail_cnt_t fail_count
);

   int violations = 0;

   // ------------------------------------------------------------
   // Controller end of run
   // ------------------------------------------------------------

   // Done lasts exactly one cycle
   done_is_pulse: assert property (@(posedge bist_clk) disable iff (!rst_b)
      bist_done |=> !bist_done)
      else begin
         violations++;
         $error("bist_done stayed high for more than one cycle");
      end

   // Done rises on the edge where busy falls
   done_on_busy_fall: assert property (@(posedge bist_clk) disable iff (!rst_b)
      bist_done |-> $fell(bist_busy))
      else begin
         violations++;
         $error("bist_done without busy falling on the same edge");
      end

   busy_fall_gives_done: assert property (@(posedge bist_clk) disable iff (!rst_b)
      $fell(bist_busy) |-> bist_done)
      else begin
         violations++;
         $error("bist_busy fell without a done pulse");
      end

   // ------------------------------------------------------------
   // Array and analyzer
   // ------------------------------------------------------------

   // Every valid result comes from a strobe one cycle earlier
   valid_needs_strobe: assert property (@(posedge bist_clk) disable iff (!rst_b)
      match_valid |-> $past(cm_en))
      else begin
         violations++;
         $error("match_valid high without a compare strobe in the previous cycle");
      end

   // Count only clears on the edge after run_start
   count_never_drops: assert property (@(posedge bist_clk) disable iff (!rst_b)
      !$past(run_start) |-> (fail_count >= $past(fail_count)))
      else begin
         violations++;
         $error("fail_count decreased within a run");
      end

endmodule

bind bcam_mbist_top bcam_mbist_properties u_props (
   .bist_clk    (bist_clk),
   .rst_b       (rst_b),
   .bist_busy   (bist_busy),
   .bist_done   (bist_done),
   .cm_en       (cm_en),
   .match_valid (match_valid),
   .run_start   (run_start),
   .fail_count  (fail_count)
);

/* sim/bcam_mbist_checker.sv */
`timescale 1ns/100ps
`include "bcam_defs.svh"

module bcam_mbist_checker (
   input logic                       bist_clk,
   input logic                       rst_b,
   input logic                       start,
   input logic                       inv,
   input logic                       func_wr_en,
   input logic                       func_cm_en,
   input bcam_mbist_pkg::cam_data_t  background,
   input bcam_mbist_pkg::cam_data_t  func_wr_data,
   input bcam_mbist_pkg::cam_data_t  func_cm_data,
   input bcam_mbist_pkg::cam_addr_t  func_wr_addr,
   input bcam_mbist_pkg::match_vec_t match,
   input logic                       match_valid,
   input logic                       bist_busy,
   input logic                       bist_done,
   input logic                       bist_fail,
   input bcam_mbist_pkg::fail_cnt_t  fail_count
);

   import bcam_mbist_pkg::*;

   localparam int DW       = `BCAM_DWIDTH;
   localparam int ENT      = `BCAM_ENTRIES;
   localparam int RUN_LEN  = ENT + 2 * DW + 2;
   localparam int PH_IDLE  = 0;
   localparam int PH_WR    = 1;
   localparam int PH_CMP   = 2;
   localparam int PH_DRAIN = 3;

   cam_data_t  m_mem [ENT];
   cam_data_t  m_mask;
   cam_data_t  m_word;
   cam_data_t  m_bg;
   logic       m_inv;
   cam_addr_t  m_entry;
   int         m_phase;
   int         m_step;
   int         cyc = 0;
   int         start_cyc = 0;
   logic       live = 1'b0;
   logic       exp_valid;
   logic       exp_done;
   logic       m_fail;
   logic       chk_pend;
   logic       chk_bad;
   logic       masked;
   logic       do_cmp;
   match_vec_t vec;
   match_vec_t exp_match;
   fail_cnt_t  m_count;
   int         errors = 0;
   int         checks = 0;

   task automatic expect_equal(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
      checks++;
      if (act_v !== exp_v) begin
         errors++;
         $display("CHECK FAILED %s expected 0x%0h actual 0x%0h at %0t",
                  name, exp_v, act_v, $time);
      end
   endtask

   // ------------------------------------------------------------
   // Reference model stepped on the rising edge
   // ------------------------------------------------------------
   always @(posedge bist_clk) begin
      live = rst_b;
      cyc  = cyc + 1;
      if (!rst_b) begin
         m_phase   = PH_IDLE;
         m_mask    = cam_data_t'(1);
         m_fail    = 1'b0;
         m_count   = '0;
         chk_pend  = 1'b0;
         exp_valid = 1'b0;
         exp_done  = 1'b0;
      end else begin
         // Analyzer verdict for last cycle's BIST compare
         if (chk_pend && chk_bad) begin
            m_fail = 1'b1;
            if (m_count != '1) begin
               m_count = m_count + 1'b1;
            end
         end
         chk_pend = 1'b0;
         exp_done = 1'b0;
         masked   = (m_phase == PH_CMP) && (m_step % 2 == 1);
         // Functional compare only taken while idle
         do_cmp   = (m_phase == PH_CMP) || (func_cm_en && (m_phase == PH_IDLE));
         m_word   = func_cm_data;
         if (m_phase == PH_CMP) begin
            m_word = m_bg ^ {DW{m_inv}};
            if (masked) begin
               m_word = m_word ^ m_mask;
            end
         end
         // Compare sees the contents before this edge's write
         if (do_cmp) begin
            for (int i = 0; i < ENT; i++) begin
               vec[cam_addr_t'(i)] = (m_mem[cam_addr_t'(i)] === m_word);
            end
            exp_match = vec;
            chk_pend  = (m_phase == PH_CMP);
            chk_bad   = masked ? (vec != '0) : (vec != '1);
         end
         exp_valid = do_cmp;
         // BIST write beats a functional one
         if (m_phase == PH_WR) begin
            m_mem[m_entry] = m_bg ^ {DW{m_inv}};
         end else if (func_wr_en) begin
            m_mem[func_wr_addr] = func_wr_data;
         end
         case (m_phase)
            PH_IDLE: begin
               if (start) begin
                  m_phase   = PH_WR;
                  m_entry   = '0;
                  m_bg      = background;
                  m_inv     = inv;
                  m_fail    = 1'b0;
                  m_count   = '0;
                  start_cyc = cyc;
               end
            end
            PH_WR: begin
               if (m_entry == cam_addr_t'(ENT - 1)) begin
                  m_phase = PH_CMP;
                  m_step  = 0;
               end else begin
                  m_entry = m_entry + 1'b1;
               end
            end
            PH_CMP: begin
               // Mask moves up one bit after each masked compare
               if (masked) begin
                  m_mask = (m_mask << 1) | (m_mask >> (DW - 1));
               end
               if (m_step == 2 * DW - 1) begin
                  m_phase = PH_DRAIN;
               end else begin
                  m_step = m_step + 1;
               end
            end
            PH_DRAIN: begin
               m_phase  = PH_IDLE;
               exp_done = 1'b1;
            end
            default: begin
               m_phase = PH_IDLE;
            end
         endcase
      end
   end

   // ------------------------------------------------------------
   // Port comparison on the falling edge
   // ------------------------------------------------------------
   always @(negedge bist_clk) begin
      if (live) begin
         expect_equal("match_valid", 32'(exp_valid), 32'(match_valid));
         if (exp_valid) begin
            expect_equal("match", 32'(exp_match), 32'(match));
         end
         expect_equal("bist_busy", 32'(m_phase != PH_IDLE), 32'(bist_busy));
         expect_equal("bist_done", 32'(exp_done), 32'(bist_done));
         if (exp_done) begin
            expect_equal("bist_fail", 32'(m_fail), 32'(bist_fail));
            expect_equal("fail_count", 32'(m_count), 32'(fail_count));
         end
         // Counted from the cycle that presents start
         if (bist_done === 1'b1) begin
            expect_equal("run_length", 32'(RUN_LEN), 32'(cyc - start_cyc + 1));
         end
      end
   end

endmodule

/* sim/bcam_mbist_tb.sv */
`timescale 1ns/100ps
`include "bcam_defs.svh"

module bcam_mbist_tb;

   import bcam_mbist_pkg::*;

   localparam int DW         = `BCAM_DWIDTH;
   localparam int ENT        = `BCAM_ENTRIES;
   localparam int RUN_LEN    = ENT + 2 * DW + 2;
   localparam int N_RUNS     = 7;
   localparam int GAP        = 4;
   localparam int FUNC_OPS   = 40;
   localparam int MAX_CYCLES = 2 * (N_RUNS * (RUN_LEN + GAP) + 5 + ENT + FUNC_OPS + GAP);

   logic       bist_clk = 1'b0;
   logic       rst_b;
   logic       start;
   logic       inv;
   logic       func_wr_en;
   logic       func_cm_en;
   cam_data_t  background;
   cam_data_t  func_wr_data;
   cam_data_t  func_cm_data;
   cam_addr_t  func_wr_addr;
   match_vec_t match;
   logic       match_valid;
   logic       bist_busy;
   logic       bist_done;
   logic       bist_fail;
   fail_cnt_t  fail_count;
   cam_data_t  shadow [ENT];
   int         cycles = 0;
   int         errors;
   int         seed;

   always #20 bist_clk = ~bist_clk;

   bcam_mbist_top DUT (.*);

   bcam_mbist_checker u_checker (.*);

   // ------------------------------------------------------------
   // Watchdog
   // ------------------------------------------------------------
   always @(posedge bist_clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout after %0d cycles, the DUT never finished the sequence", cycles);
         $display("Test failed");
         $finish;
      end
   end

   // One functional cycle, entered and left on a falling edge
   task automatic func_op(input logic wr, input cam_addr_t addr, input cam_data_t wdata,
                          input logic cm, input cam_data_t cdata);
      func_wr_en   = wr;
      func_wr_addr = addr;
      func_wr_data = wdata;
      func_cm_en   = cm;
      func_cm_data = cdata;
      @(negedge bist_clk);
      func_wr_en = 1'b0;
      func_cm_en = 1'b0;
   endtask

   task automatic random_func_ops(input int n);
      cam_addr_t a;
      cam_data_t d;
      cam_data_t c;
      logic      wr;
      for (int i = 0; i < n; i++) begin
         a  = cam_addr_t'($urandom);
         d  = cam_data_t'($urandom);
         wr = ($urandom_range(1) == 1);
         // Mostly stored words so that hits occur
         c  = ($urandom_range(3) != 0) ? shadow[cam_addr_t'($urandom)] : cam_data_t'($urandom);
         func_op(wr, a, d, $urandom_range(3) != 0, c);
         if (wr) begin
            shadow[a] = d;
         end
      end
   endtask

   // corrupt writes one entry in the compare phase
   // noise toggles start and func_cm_en while busy
   task automatic run_bist(input logic corrupt, input logic noise);
      cam_data_t bg;
      logic      iv;
      int        k;
      int        wr_at;
      bg    = cam_data_t'($urandom);
      iv    = 1'($urandom_range(1));
      wr_at = -1;
      if (corrupt) begin
         wr_at = ENT + 1 + int'($urandom_range(2 * DW - 1));
      end else if (noise) begin
         // Lands in the write phase where the BIST write wins
         wr_at = 1 + int'($urandom_range(ENT - 1));
      end
      background = bg;
      inv        = iv;
      start      = 1'b1;
      k          = 0;
      do begin
         @(negedge bist_clk);
         k++;
         start        = noise && ($urandom_range(1) == 1);
         func_cm_en   = noise && ($urandom_range(1) == 1);
         func_cm_data = cam_data_t'($urandom);
         func_wr_en   = (k == wr_at);
         func_wr_addr = cam_addr_t'($urandom);
         func_wr_data = cam_data_t'($urandom);
         if (noise) begin
            background = cam_data_t'($urandom);
            inv        = 1'($urandom_range(1));
         end
      end while (bist_done !== 1'b1);
      start      = 1'b0;
      func_cm_en = 1'b0;
      func_wr_en = 1'b0;
      // Read back the run's word from every entry
      func_op(1'b0, '0, '0, 1'b1, bg ^ {DW{iv}});
      repeat (GAP - 2) @(negedge bist_clk);
   endtask

   initial begin
      seed         = $urandom(85797);
      rst_b        = 1'b0;
      start        = 1'b0;
      inv          = 1'b0;
      func_wr_en   = 1'b0;
      func_cm_en   = 1'b0;
      background   = '0;
      func_wr_data = '0;
      func_cm_data = '0;
      func_wr_addr = '0;
      repeat (5) @(negedge bist_clk);
      rst_b = 1'b1;
      // Fill every entry before the first compare
      for (int i = 0; i < ENT; i++) begin
         shadow[cam_addr_t'(i)] = cam_data_t'($urandom);
         func_op(1'b1, cam_addr_t'(i), shadow[cam_addr_t'(i)], 1'b0, '0);
      end
      random_func_ops(FUNC_OPS);
      repeat (3) run_bist(1'b0, 1'b0);
      repeat (3) run_bist(1'b1, 1'b0);
      run_bist(1'b0, 1'b1);
      errors = u_checker.errors + DUT.u_props.violations;
      $display("Closing report %0d checks, %0d mismatches, %0d assertion failures",
               u_checker.checks, u_checker.errors, DUT.u_props.violations);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* filelist.f */
+incdir+src
src/bcam_mbist_pkg.sv
src/bcam_mbist_ctrl.sv
src/bcam_mbist_inhandler.sv
src/bcam_array.sv
src/bcam_mbist_resp.sv
src/bcam_mbist_top.sv
sim/bcam_mbist_properties.sv
sim/bcam_mbist_checker.sv
sim/bcam_mbist_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the BCAM MBIST testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -f filelist.f --top-module bcam_mbist_tb -o bcam_sim

# Keep running past assertion errors so the closing report is printed
status=0
./obj_dir/bcam_sim +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

# Pass only when the pass line is in the log
grep -qx "Test passed" sim.log
echo "Simulation finished with status $status"
